// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,  // FENCE, runs as a no-op
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111
    } opcode_e;

    ////////////////////
    // funct3 codes

    localparam logic [2:0] F3_ADD    = 3'b000;  // ADD/SUB/ADDI
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SR     = 3'b101;  // SRL/SRA, funct7[5] picks
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;
    localparam logic [2:0] F3_BLT    = 3'b100;
    localparam logic [2:0] F3_BGE    = 3'b101;
    localparam logic [2:0] F3_BLTU   = 3'b110;
    localparam logic [2:0] F3_BGEU   = 3'b111;

    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

    ////////////////////
    // Instruction formats

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;  // Bits 31:12 of the value
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_instr_t;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;

    // One enable per byte lane of the bus
    typedef logic [XLEN/8-1:0] bytesel_t;

    typedef enum logic [1:0] {
        ST_FETCH,   // Instruction fetch, non-memory ops retire here
        ST_MEM_RD,  // Load data access
        ST_MEM_WR   // Store data access
    } core_state_e;

endpackage

// ==== logic/register_file.sv ====
module register_file import core_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] rs1_idx,
    input  logic [REG_ADDR_W-1:0] rs2_idx,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic                  rd_wr,
    input  logic [REG_ADDR_W-1:0] rd_idx,
    input  logic [XLEN-1:0]       rd_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];  // Distributed RAM, entry 0 never written

    always_ff @(posedge clk) begin
        if (rd_wr && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== logic/alu.sv ====
module alu import core_pkg::*, rv_isa_pkg::*; (
    input  rv_instr_t       instr,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic [XLEN-1:0] result,
    output logic            branch_taken,
    output logic [XLEN-1:0] target
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic            is_op;
    logic            is_branch;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] sra;
    logic            is_eq;
    logic            is_lt;
    logic            is_ltu;

    ////////////////////
    // Immediates and operands

    assign imm_i = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_b = {{(XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                    instr.b.imm_4_1, 1'b0};
    assign imm_j = {{(XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                    instr.j.imm_10_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'b0};

    assign is_op     = instr.r.opcode == OPC_OP;
    assign is_branch = instr.r.opcode == OPC_BRANCH;

    assign op_b  = (is_op || is_branch) ? rs2_data : imm_i;
    assign shamt = is_op ? rs2_data[4:0] : instr.i.imm[4:0];

    ////////////////////
    // Compare and shift

    assign diff   = {1'b0, rs1_data} - {1'b0, op_b};
    assign is_eq  = diff[XLEN-1:0] == '0;
    assign is_ltu = diff[XLEN];  // Borrow out
    assign is_lt  = (rs1_data[XLEN-1] ^ op_b[XLEN-1]) ? rs1_data[XLEN-1] : diff[XLEN];
    assign sra    = $signed(rs1_data) >>> shamt;

    always_comb begin
        case (instr.r.funct3)
            F3_ADD:  result = (is_op && instr.r.funct7[5]) ? diff[XLEN-1:0] : rs1_data + op_b;
            F3_SLL:  result = rs1_data << shamt;
            F3_SLT:  result = XLEN'(is_lt);
            F3_SLTU: result = XLEN'(is_ltu);
            F3_XOR:  result = rs1_data ^ op_b;
            F3_SR:   result = instr.r.funct7[5] ? sra : rs1_data >> shamt;
            F3_OR:   result = rs1_data | op_b;
            default: result = rs1_data & op_b;  // AND
        endcase
    end

    ////////////////////
    // Branch and targets

    always_comb begin
        branch_taken = 1'b0;
        if (is_branch) begin
            case (instr.b.funct3)
                F3_BEQ:  branch_taken = is_eq;
                F3_BNE:  branch_taken = !is_eq;
                F3_BLT:  branch_taken = is_lt;
                F3_BGE:  branch_taken = !is_lt;
                F3_BLTU: branch_taken = is_ltu;
                F3_BGEU: branch_taken = !is_ltu;
                default: branch_taken = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (instr.r.opcode)
            OPC_JAL:   target = pc + imm_j;
            OPC_JALR:  target = (rs1_data + imm_i) & ~XLEN'(1);
            OPC_AUIPC: target = pc + imm_u;
            default:   target = pc + imm_b;
        endcase
    end

endmodule

// ==== logic/load_store_unit.sv ====
module load_store_unit import core_pkg::*, rv_isa_pkg::*; (
    input  rv_instr_t       instr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] bus_rddata,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] store_data,
    output bytesel_t        store_bytesel,
    output logic [XLEN-1:0] load_data
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic            is_load;
    logic            is_store;
    logic [1:0]      lane;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;

    assign is_load  = instr.i.opcode == OPC_LOAD;
    assign is_store = instr.s.opcode == OPC_STORE;

    assign imm_i    = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s    = {{(XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign mem_addr = rs1_data + (is_store ? imm_s : imm_i);
    assign lane     = mem_addr[1:0];

    ////////////////////
    // Store lanes

    always_comb begin
        case (instr.s.funct3)
            F3_BYTE: begin
                store_data    = {4{rs2_data[7:0]}};
                store_bytesel = bytesel_t'(1) << lane;
            end
            F3_HALF: begin
                store_data    = {2{rs2_data[15:0]}};
                store_bytesel = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin  // SW
                store_data    = rs2_data;
                store_bytesel = '1;
            end
        endcase
    end

    ////////////////////
    // Load extraction

    assign ld_byte = bus_rddata[{lane, 3'b000} +: 8];
    assign ld_half = lane[1] ? bus_rddata[31:16] : bus_rddata[15:0];

    always_comb begin
        case (instr.i.funct3)
            F3_BYTE:   load_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            F3_BYTE_U: load_data = {{(XLEN-8){1'b0}}, ld_byte};
            F3_HALF:   load_data = {{(XLEN-16){ld_half[15]}}, ld_half};
            F3_HALF_U: load_data = {{(XLEN-16){1'b0}}, ld_half};
            default:   load_data = bus_rddata;  // LW
        endcase
    end

    // Halfwords on even addresses, words on multiples of four
    always_comb begin
        if (is_load || is_store) begin
            a_aligned: assert final (instr.i.funct3[1] ? lane == 2'b00
                                                       : !(instr.i.funct3[0] && lane[0]))
                else $error("Misaligned access at %h", mem_addr);
        end
    end

endmodule

// ==== core/core_control.sv ====
module core_control import core_pkg::*, rv_isa_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_VECTOR = 32'hff10_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_wait,
    input  logic [XLEN-1:0]       bus_rddata,

    output rv_instr_t             instr,
    output logic [XLEN-1:0]       pc,

    input  logic [XLEN-1:0]       result,
    input  logic [XLEN-1:0]       target,
    input  logic                  branch_taken,

    input  logic [XLEN-1:0]       mem_addr,
    input  logic [XLEN-1:0]       store_data,
    input  bytesel_t              store_bytesel,
    input  logic [XLEN-1:0]       load_data,

    output logic                  rd_wr,
    output logic [REG_ADDR_W-1:0] rd_idx,
    output logic [XLEN-1:0]       rd_data,

    output logic [XLEN-1:0]       bus_addr,
    output logic [XLEN-1:0]       bus_wrdata,
    output bytesel_t              bus_bytesel,
    output logic                  bus_wren,
    output logic                  bus_strobe
);

    core_state_e     state;
    rv_instr_t       instr_reg;     // Held for the data access
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] fetch_pc;
    logic            is_load;
    logic            is_store;
    logic            is_jump;
    logic            writes_rd;
    logic            fetch_done;
    logic            mem_done;
    logic            start_fetch;

    ////////////////////
    // Decode

    // Fetched word goes straight to the datapath in its completing cycle
    always_comb begin
        if (state != ST_FETCH) begin
            instr = instr_reg;
        end else if (bus_wait) begin
            instr = '0;  // Nothing to decode yet
        end else begin
            instr = bus_rddata;
        end
    end

    assign is_load   = instr.r.opcode == OPC_LOAD;
    assign is_store  = instr.r.opcode == OPC_STORE;
    assign is_jump   = instr.r.opcode inside {OPC_JAL, OPC_JALR};
    assign writes_rd = instr.r.opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                              OPC_OP_IMM, OPC_OP};

    assign fetch_done  = state == ST_FETCH && !bus_wait;
    assign mem_done    = state != ST_FETCH && !bus_wait;
    assign start_fetch = (fetch_done && !(is_load || is_store)) || mem_done;

    assign pc_plus4 = pc + XLEN'(4);
    assign next_pc  = (is_jump || branch_taken) ? target : pc_plus4;
    assign fetch_pc = {next_pc[XLEN-1:2], 2'b00};  // Word aligned fetch

    ////////////////////
    // Write-back

    assign rd_idx = instr.r.rd;
    assign rd_wr  = (fetch_done && writes_rd) || (mem_done && state == ST_MEM_RD);

    always_comb begin
        case (instr.r.opcode)
            OPC_LUI:            rd_data = {instr.u.imm, 12'b0};
            OPC_AUIPC:          rd_data = target;  // pc + upper imm
            OPC_JAL, OPC_JALR:  rd_data = pc_plus4;
            OPC_LOAD:           rd_data = load_data;
            OPC_OP, OPC_OP_IMM: rd_data = result;
            default:            rd_data = '0;
        endcase
    end

    ////////////////////
    // State and bus registers

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ST_FETCH;
            pc          <= RESET_VECTOR;
            bus_addr    <= RESET_VECTOR;
            bus_wrdata  <= '0;
            bus_bytesel <= '1;
            bus_wren    <= 1'b0;
            bus_strobe  <= 1'b1;
        end else begin
            bus_strobe <= 1'b1;  // Always one transfer outstanding
            if (fetch_done && (is_load || is_store)) begin
                state       <= is_load ? ST_MEM_RD : ST_MEM_WR;
                bus_addr    <= mem_addr;
                bus_bytesel <= is_store ? store_bytesel : '1;
                bus_wren    <= is_store;
                if (is_store) begin
                    bus_wrdata <= store_data;
                end
            end else if (start_fetch) begin
                state       <= ST_FETCH;
                pc          <= fetch_pc;
                bus_addr    <= fetch_pc;
                bus_bytesel <= '1;
                bus_wren    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_reg <= bus_rddata;
        end
    end

    // A stalled request must not change under the memory
    a_bus_hold: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && bus_wait |=>
            $stable({bus_addr, bus_wrdata, bus_bytesel, bus_wren, bus_strobe}));

endmodule

// ==== core/core_top.sv ====
module core_top import core_pkg::*, rv_isa_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_VECTOR = 32'hff10_0000
) (
    input  logic            clk,
    input  logic            reset,

    output logic [XLEN-1:0] bus_addr,
    output logic [XLEN-1:0] bus_wrdata,
    output bytesel_t        bus_bytesel,
    output logic            bus_wren,
    output logic            bus_strobe,
    input  logic            bus_wait,
    input  logic [XLEN-1:0] bus_rddata
);

    rv_instr_t             instr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       result;
    logic                  branch_taken;
    logic [XLEN-1:0]       target;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       store_data;
    bytesel_t              store_bytesel;
    logic [XLEN-1:0]       load_data;
    logic                  rd_wr;
    logic [REG_ADDR_W-1:0] rd_idx;
    logic [XLEN-1:0]       rd_data;

    core_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_control (
        .clk           (clk),
        .reset         (reset),
        .bus_wait      (bus_wait),
        .bus_rddata    (bus_rddata),
        .instr         (instr),
        .pc            (pc),
        .result        (result),
        .target        (target),
        .branch_taken  (branch_taken),
        .mem_addr      (mem_addr),
        .store_data    (store_data),
        .store_bytesel (store_bytesel),
        .load_data     (load_data),
        .rd_wr         (rd_wr),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .bus_addr      (bus_addr),
        .bus_wrdata    (bus_wrdata),
        .bus_bytesel   (bus_bytesel),
        .bus_wren      (bus_wren),
        .bus_strobe    (bus_strobe)
    );

    register_file u_regs (
        .clk      (clk),
        .rs1_idx  (instr.r.rs1),
        .rs2_idx  (instr.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_wr    (rd_wr),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    alu u_alu (
        .instr        (instr),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result       (result),
        .branch_taken (branch_taken),
        .target       (target)
    );

    load_store_unit u_lsu (
        .instr         (instr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .bus_rddata    (bus_rddata),
        .mem_addr      (mem_addr),
        .store_data    (store_data),
        .store_bytesel (store_bytesel),
        .load_data     (load_data)
    );

endmodule

// ==== tb/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;  // Released on a rising edge
    end

    always #4 clk = ~clk;  // Period 8

endmodule

// ==== tb/tb_core.sv ====
module tb_core import rv_isa_pkg::*;;

    localparam logic [31:0] RESET_VEC = 32'h0000_0100;
    localparam logic [31:0] MARKER    = 32'h0bad_f00d;

    logic        clk;
    logic        reset;
    logic [31:0] bus_addr;
    logic [31:0] bus_wrdata;
    logic [3:0]  bus_bytesel;
    logic        bus_wren;
    logic        bus_strobe;
    logic        bus_wait;
    logic [31:0] bus_rddata;

    logic [31:0] mem [4096];
    logic [31:0] rng_state;
    int          wait_left;
    logic [31:0] pc_b;       // Next program address
    logic [31:0] res_addr;   // Next result slot
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    logic [3:0]  exp_sel_q[$];
    logic [31:0] act_addr_q[$];
    logic [31:0] act_data_q[$];
    logic [3:0]  act_sel_q[$];

    clock_gen u_clk (.clk(clk), .reset(reset));

    core_top #(.RESET_VECTOR(RESET_VEC)) DUT (
        .clk(clk), .reset(reset), .bus_addr(bus_addr), .bus_wrdata(bus_wrdata),
        .bus_bytesel(bus_bytesel), .bus_wren(bus_wren), .bus_strobe(bus_strobe),
        .bus_wait(bus_wait), .bus_rddata(bus_rddata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    ////////////////////
    // Memory model

    always @(posedge clk) begin
        if (!reset && bus_strobe) begin
            if (bus_wait) begin
                if (wait_left == 0) begin
                    bus_wait   <= 1'b0;
                    bus_rddata <= mem[bus_addr[13:2]];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else begin  // Transfer completes at this edge
                if (bus_wren) begin
                    for (int i = 0; i < 4; i++) begin
                        if (bus_bytesel[i]) mem[bus_addr[13:2]][8*i +: 8] = bus_wrdata[8*i +: 8];
                    end
                    act_addr_q.push_back(bus_addr);
                    act_data_q.push_back(bus_wrdata);
                    act_sel_q.push_back(bus_bytesel);
                end
                bus_wait  <= 1'b1;
                wait_left <= int'(next_rand() % 32'd3);  // 0 to 2 extra waits
            end
        end
    end

    ////////////////////
    // Reference model

    function automatic logic [31:0] alu_ref(int f3, logic alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return alt ? a - b : a + b;
            1:       return a << b[4:0];
            2:       return {31'b0, $signed(a) < $signed(b)};
            3:       return {31'b0, a < b};
            4:       return a ^ b;
            5:       return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(int f3, logic [31:0] w, int off);
        logic [7:0]  bt;
        logic [15:0] hw;
        bt = w[8*off +: 8];
        hw = w[8*(off & 2) +: 16];
        case (f3)
            0:       return {{24{bt[7]}}, bt};
            4:       return {24'b0, bt};
            1:       return {{16{hw[15]}}, hw};
            5:       return {16'b0, hw};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] merge_ref(logic [31:0] old, logic [31:0] d, logic [3:0] sel);
        logic [31:0] m;
        m = old;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) m[8*i +: 8] = d[8*i +: 8];
        end
        return m;
    endfunction

    ////////////////////
    // Instruction encoders

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {imm, 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, int f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
    endfunction

    ////////////////////
    // Program builder

    task automatic emit(logic [31:0] w);
        mem[pc_b[13:2]] = w;
        pc_b = pc_b + 32'd4;
    endtask

    task automatic load_imm(int rd, logic [31:0] val);
        logic [31:0] s;
        s = val + 32'h800;  // Compensates the sign of the ADDI part
        emit({s[31:12], 5'(rd), OPC_LUI});
        emit(enc_i(val[11:0], rd, 0, rd, OPC_OP_IMM));
    endtask

    task automatic expect_store(logic [31:0] addr, logic [31:0] data, logic [3:0] sel);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_sel_q.push_back(sel);
    endtask

    task automatic emit_result(int rs);
        emit(enc_s(12'd0, rs, 31, 2));
        emit(enc_i(12'd4, 31, 0, 31, OPC_OP_IMM));
    endtask

    task automatic store_result(int rs, logic [31:0] val);
        emit_result(rs);
        expect_store(res_addr, val, 4'hf);
        res_addr = res_addr + 32'd4;
    endtask

    task automatic alu_case(logic is_imm, int f3, logic alt, logic [31:0] a, logic [31:0] b,
                            logic [11:0] imm);
        logic [11:0] iw;
        logic [31:0] opb;
        iw = (f3 == 1 || f3 == 5) ? {(alt ? 7'h20 : 7'h00), imm[4:0]} : imm;
        opb = is_imm ? {{20{iw[11]}}, iw} : b;
        if (is_imm) emit(enc_i(iw, 1, f3, 3, OPC_OP_IMM));
        else emit(enc_r(alt ? 32 : 0, 2, 1, f3, 3));
        store_result(3, alu_ref(f3, alt, a, opb));
    endtask

    task automatic branch_case(int f3, logic [31:0] a, logic [31:0] b);
        load_imm(1, a);
        load_imm(2, b);
        emit(enc_b(13'd12, 2, 1, f3));  // Taken skips the marker store
        emit_result(5);
        if (!branch_ref(f3, a, b)) begin
            expect_store(res_addr, MARKER, 4'hf);
            res_addr = res_addr + 32'd4;
        end
        store_result(1, a);
    endtask

    task automatic sub_store(int f3, int off, int slot);
        logic [31:0] w;
        logic [31:0] old;
        logic [31:0] d;
        logic [31:0] rep;
        logic [3:0]  sel;
        w = 32'h2800 + 32'(4 * slot);
        old = next_rand();
        mem[w[13:2]] = old;
        d = next_rand();
        rep = (f3 == 0) ? {4{d[7:0]}} : {2{d[15:0]}};
        sel = (f3 == 0) ? 4'(1 << off) : ((off == 2) ? 4'b1100 : 4'b0011);
        load_imm(9, w);
        load_imm(1, d);
        emit(enc_s(12'(off), 1, 9, f3));
        expect_store(w + 32'(off), rep, sel);
        emit(enc_i(12'd0, 9, 2, 3, OPC_LOAD));
        store_result(3, merge_ref(old, rep, sel));
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        logic [31:0] lw_word;
        int          lf3 [5];
        for (int i = 0; i < 4096; i++) mem[i] = 32'(i) * 32'h9e37_79b9;
        pc_b = RESET_VEC;
        res_addr = 32'h3000;
        load_imm(31, res_addr);
        load_imm(5, MARKER);
        emit(32'h0000_000f);  // FENCE
        for (int p_i = 0; p_i < 4; p_i++) begin
            a = next_rand();
            b = next_rand();
            load_imm(1, a);
            load_imm(2, b);
            for (int f3 = 0; f3 < 8; f3++) begin
                alu_case(1'b0, f3, 1'b0, a, b, 12'd0);
                if (f3 == 0 || f3 == 5) alu_case(1'b0, f3, 1'b1, a, b, 12'd0);
                alu_case(1'b1, f3, 1'b0, a, b, 12'(next_rand()));
                if (f3 == 5) alu_case(1'b1, f3, 1'b1, a, b, 12'(next_rand()));
            end
        end
        a = next_rand();
        b = a ^ 32'h8000_0001;  // Opposite sign so signed and unsigned order differ
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) begin
                branch_case(f3, a, a);
                branch_case(f3, a, b);
                branch_case(f3, b, a);
            end
        end
        p = pc_b;
        emit(enc_j(21'd12, 3));
        emit_result(5);
        store_result(3, p + 32'd4);
        load_imm(4, pc_b + 32'd16);
        p = pc_b;
        emit(enc_i(12'd4, 4, 0, 3, OPC_JALR));
        emit_result(5);
        store_result(3, p + 32'd4);
        p = pc_b;
        emit({20'h12345, 5'd3, OPC_AUIPC});  // x3 = pc + upper immediate
        store_result(3, p + 32'h1234_5000);
        for (int off = 0; off < 4; off++) sub_store(0, off, off);
        sub_store(1, 0, 4);
        sub_store(1, 2, 5);
        lw_word = next_rand();
        mem[12'(32'h2900 >> 2)] = lw_word;
        load_imm(8, 32'h2900);
        lf3 = '{0, 4, 1, 5, 2};
        foreach (lf3[k]) begin
            for (int off = 0; off < 4; off++) begin
                if ((lf3[k] == 2 && off == 0) || (lf3[k] % 4 == 1 && off % 2 == 0) ||
                    lf3[k] % 4 == 0) begin
                    emit(enc_i(12'(off), 8, lf3[k], 3, OPC_LOAD));
                    store_result(3, load_ref(lf3[k], lw_word, off));
                end
            end
        end
        emit(enc_j(21'd0, 0));  // Spin here
    endtask

    ////////////////////
    // Checks

    task automatic check_value(string name, logic [31:0] act, logic [31:0] exp);
        if (act !== exp) begin
            $display("Error: time %0t %s actual %h expected %h", $time, name, act, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    initial begin
        int cnt;
        bus_wait   = 1'b1;
        bus_rddata = '0;
        wait_left  = 0;
        rng_state  = 32'hcd629757;
        build_program();
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > 20) timeout_fail("reset release");
        end while (reset);
        @(negedge clk);
        check_value("bus_strobe", {31'b0, bus_strobe}, 32'd1);
        check_value("bus_addr", bus_addr, RESET_VEC);
        check_value("bus_bytesel", {28'b0, bus_bytesel}, 32'hf);
        check_value("bus_wren", {31'b0, bus_wren}, 32'd0);
        for (int i = 0; i < exp_addr_q.size(); i++) begin
            cnt = 0;
            while (act_addr_q.size() == 0) begin
                @(negedge clk);
                cnt++;
                if (cnt > 500) timeout_fail("the next store on the bus");
            end
            check_value("bus_addr", act_addr_q.pop_front(), exp_addr_q[i]);
            check_value("bus_wrdata", act_data_q.pop_front(), exp_data_q[i]);
            check_value("bus_bytesel", {28'b0, act_sel_q.pop_front()}, {28'b0, exp_sel_q[i]});
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
common/rv_isa_pkg.sv
common/core_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/load_store_unit.sv
core/core_control.sv
core/core_top.sv
tb/clock_gen.sv
tb/tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_core -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
